// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dacfifo_wr
FILELIST  ?= vlog.f
TRACE     ?= dacfifo_trace.txt
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile $(TRACE)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^No errors$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dacfifo_avl_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dacfifo_avl_writer import dacfifo_pkg::*; (
  input  wire                               avl_clk,
  input  wire                               avl_reset,
  input  wire                               flush_active,
  input  wire                               fetch_enable,
  input  wire                               final_word,
  input  avl_word_u                         rd_data,
  input  wire                               avl_ready,
  output logic [AVL_MEM_ADDRESS_WIDTH-1:0]  rd_addr,
  output logic                              avl_write,
  output logic [AVL_ADDRESS_WIDTH-1:0]      avl_address,
  output logic [AVL_DATA_WIDTH-1:0]         avl_data
);

  logic read_pend;
  logic fetch_s;
  logic accept_s;

  assign accept_s = avl_write & avl_ready;

  // one word in flight at a time, so a read only starts once the
  // previous write is gone; this also leaves two idle cycles between writes
  assign fetch_s = fetch_enable & ~read_pend & ~avl_write;

  // ************************************************************
  // read to write pipeline
  // ************************************************************

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      read_pend <= 1'b0;
      avl_write <= 1'b0;
    end else begin
      read_pend <= fetch_s;
      if (read_pend) begin
        avl_write <= 1'b1;
      end else if (accept_s) begin
        avl_write <= 1'b0;
      end
    end
  end

  // buffer word is valid the cycle after the read was issued
  always_ff @(posedge avl_clk) begin
    if (read_pend) begin
      avl_data <= rd_data.flat;
    end
  end

  // ************************************************************
  // pointers
  // ************************************************************

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      rd_addr <= '0;
      avl_address <= AVL_DDR_BASE_ADDRESS;
    end else if (!flush_active) begin
      rd_addr <= '0;
      avl_address <= AVL_DDR_BASE_ADDRESS;
    end else if (accept_s) begin
      rd_addr <= rd_addr + 1'b1;
      if (avl_address == AVL_DDR_ADDRESS_LIMIT) begin
        avl_address <= AVL_DDR_BASE_ADDRESS;
      end else begin
        avl_address <= avl_address + 1'b1;
      end
    end
  end

  a_addr_window: assert property (@(posedge avl_clk) disable iff (avl_reset)
    (avl_address >= AVL_DDR_BASE_ADDRESS) && (avl_address <= AVL_DDR_ADDRESS_LIMIT));

  // a stalled write keeps its strobe, address and data
  a_hold_while_waiting: assert property (@(posedge avl_clk) disable iff (avl_reset)
    (avl_write && !avl_ready) |=> (avl_write && $stable(avl_address) && $stable(avl_data)));

  // the final word closes the flush in flush_ctrl
  a_final_ends_flush: assert property (@(posedge avl_clk) disable iff (avl_reset)
    (accept_s && final_word) |=> (!flush_active && !avl_write));

endmodule

`default_nettype wire

// ==== dacfifo_beat_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dacfifo_beat_packer import dacfifo_pkg::*; (
  input  wire                               avl_clk,
  input  wire                               avl_reset,
  input  wire  [DMA_DATA_WIDTH-1:0]         dma_data,
  input  wire                               dma_valid,
  input  wire                               dma_xfer_req,
  input  wire                               dma_xfer_last,
  output logic                              dma_ready_out,
  output logic                              wr_en,
  output logic [DMA_MEM_ADDRESS_WIDTH-1:0]  wr_addr,
  output logic [DMA_DATA_WIDTH-1:0]         wr_data,
  output logic                              flush_start,
  output logic [AVL_MEM_ADDRESS_WIDTH:0]    word_count,
  output logic [LANE_WIDTH-1:0]             last_lane
);

  logic                            xfer_req_d;
  logic                            frame_open_s;
  logic                            last_seen;
  logic                            last_seen_next;
  logic [DMA_MEM_ADDRESS_WIDTH:0]  beat_count;
  logic [DMA_MEM_ADDRESS_WIDTH:0]  beat_count_next;
  logic [DMA_MEM_ADDRESS_WIDTH:0]  beat_round;

  assign frame_open_s = dma_xfer_req & ~xfer_req_d;

  // beats after the one flagged last are not taken
  assign wr_en = dma_valid & dma_xfer_req & ~last_seen;
  assign wr_addr = beat_count[DMA_MEM_ADDRESS_WIDTH-1:0];
  assign wr_data = dma_data;

  always_comb begin
    if (frame_open_s) begin
      beat_count_next = '0;
      last_seen_next = 1'b0;
    end else begin
      beat_count_next = beat_count + {{DMA_MEM_ADDRESS_WIDTH{1'b0}}, wr_en};
      last_seen_next = last_seen | (wr_en & dma_xfer_last);
    end
  end

  // beats rounded up to whole words
  assign beat_round = beat_count + (DMA_MEM_ADDRESS_WIDTH+1)'(MEM_RATIO - 1);
  assign word_count = beat_round[DMA_MEM_ADDRESS_WIDTH:LANE_WIDTH];

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      xfer_req_d <= 1'b0;
      last_seen <= 1'b0;
      beat_count <= '0;
      dma_ready_out <= 1'b0;
      flush_start <= 1'b0;
      last_lane <= '0;
    end else begin
      xfer_req_d <= dma_xfer_req;
      last_seen <= last_seen_next;
      beat_count <= beat_count_next;
      // ready follows the count after this edge
      dma_ready_out <= dma_xfer_req & ~last_seen_next &
                       (beat_count_next < DMA_BUF_THRESHOLD_HI);
      // frame close, request seen falling
      flush_start <= xfer_req_d & ~dma_xfer_req;
      if (wr_en) begin
        last_lane <= beat_count[LANE_WIDTH-1:0];
      end
    end
  end

  // source keeps to the ready handshake inside a frame
  a_valid_needs_ready: assert property (@(posedge avl_clk) disable iff (avl_reset)
    (dma_xfer_req && dma_valid) |-> dma_ready_out);

endmodule

`default_nettype wire

// ==== dacfifo_flush_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dacfifo_flush_ctrl import dacfifo_pkg::*; (
  input  wire                              avl_clk,
  input  wire                              avl_reset,
  input  wire                              dma_xfer_req,
  input  wire                              flush_start,
  input  wire  [AVL_MEM_ADDRESS_WIDTH:0]   word_count,
  input  wire  [LANE_WIDTH-1:0]            last_lane,
  input  wire                              avl_write,
  input  wire                              avl_ready,
  input  wire  [AVL_ADDRESS_WIDTH-1:0]     avl_address,
  output logic                             fetch_enable,
  output logic                             final_word,
  output logic                             flush_active,
  output logic [AVL_BE_WIDTH-1:0]          avl_byteenable,
  output logic [AVL_ADDRESS_WIDTH-1:0]     avl_last_address,
  output logic [AVL_BE_WIDTH-1:0]          avl_last_byteenable,
  output logic                             avl_xfer_req
);

  logic [AVL_MEM_ADDRESS_WIDTH:0] done_count;
  logic [LANE_WIDTH:0]            last_beats;
  logic                           accept_s;
  logic                           flush_done_s;

  assign accept_s = avl_write & avl_ready;

  // words written so far equal words fetched, only one is ever in flight
  assign fetch_enable = flush_active & (done_count < word_count);
  assign final_word = flush_active & ((done_count + 1'b1) == word_count);

  // final word enables only the bytes of the beats it holds
  assign last_beats = {1'b0, last_lane} + 1'b1;
  assign avl_byteenable = final_word ?
                          ~({AVL_BE_WIDTH{1'b1}} << (last_beats * DMA_BYTES)) : '1;

  // empty frames finish right away
  assign flush_done_s = (flush_start & (word_count == '0)) | (accept_s & final_word);

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      flush_active <= 1'b0;
      done_count <= '0;
      avl_last_address <= '0;
      avl_last_byteenable <= '0;
      avl_xfer_req <= 1'b0;
    end else begin
      if (flush_start) begin
        flush_active <= (word_count != '0);
        done_count <= '0;
      end else if (accept_s && flush_active) begin
        done_count <= done_count + 1'b1;
        if (final_word) begin
          flush_active <= 1'b0;
        end
      end
      if (accept_s && final_word) begin
        avl_last_address <= avl_address;
        avl_last_byteenable <= avl_byteenable;
      end
      // ready flag for the read side, dropped once a new frame opens
      if (flush_done_s) begin
        avl_xfer_req <= 1'b1;
      end else if (dma_xfer_req) begin
        avl_xfer_req <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dacfifo_pkg.sv ====
`default_nettype none

package dacfifo_pkg;

  // ************************************************************
  // dma beat side
  // ************************************************************

  localparam int DMA_DATA_WIDTH = 16;
  localparam int MEM_RATIO = 4;
  localparam int DMA_BYTES = DMA_DATA_WIDTH / 8;
  localparam int LANE_WIDTH = $clog2(MEM_RATIO);

  // buffer geometry, 64 beats or 16 words
  localparam int DMA_MEM_ADDRESS_WIDTH = 6;
  localparam int AVL_MEM_ADDRESS_WIDTH = DMA_MEM_ADDRESS_WIDTH - LANE_WIDTH;

  // ready drops once this many beats sit in the buffer
  localparam int DMA_BUF_THRESHOLD_HI = 60;

  // ************************************************************
  // avalon side
  // ************************************************************

  localparam int AVL_DATA_WIDTH = DMA_DATA_WIDTH * MEM_RATIO;
  localparam int AVL_BE_WIDTH = AVL_DATA_WIDTH / 8;
  localparam int AVL_ADDRESS_WIDTH = 25;

  // external word window, wraps from limit back to base
  localparam logic [AVL_ADDRESS_WIDTH-1:0] AVL_DDR_BASE_ADDRESS = 25'd4;
  localparam logic [AVL_ADDRESS_WIDTH-1:0] AVL_DDR_ADDRESS_LIMIT = 25'd12;

  // one buffer word, seen whole or as beat lanes (lane 0 in the low bits)
  typedef union packed {
    logic [AVL_DATA_WIDTH-1:0] flat;
    logic [MEM_RATIO-1:0][DMA_DATA_WIDTH-1:0] lanes;
  } avl_word_u;

endpackage

`default_nettype wire

// ==== dacfifo_trace.txt ====
# test  beats  stall  acc_beats  writes  last_addr  last_be(hex)
# stall 0 keeps avl_ready high, 1 draws avl_ready from the lfsr
# whole words
1   32  0  32   8  11  ff
# partial final word, two beats in it
2   22  0  22   6   9  0f
# back-pressure, one beat in the final word
3   25  1  25   7  10  03
# address wrap after the limit
4   48  0  48  12   6  ff
# buffer threshold, 70 offered
5   70  0  60  15   9  ff
# status sequencing, short frame under back-pressure
6    6  1   6   2   5  0f

// ==== dacfifo_word_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dacfifo_word_buffer import dacfifo_pkg::*; (
  input  wire                              avl_clk,
  input  wire                              wr_en,
  input  wire [DMA_MEM_ADDRESS_WIDTH-1:0]  wr_addr,
  input  wire [DMA_DATA_WIDTH-1:0]         wr_data,
  input  wire [AVL_MEM_ADDRESS_WIDTH-1:0]  rd_addr,
  output avl_word_u                        rd_data
);

  localparam int DEPTH = 2 ** AVL_MEM_ADDRESS_WIDTH;

  avl_word_u                        mem [DEPTH];
  logic [AVL_MEM_ADDRESS_WIDTH-1:0] wr_word;
  logic [LANE_WIDTH-1:0]            wr_lane;

  // high bits pick the word, low bits the lane inside it
  assign wr_word = wr_addr[DMA_MEM_ADDRESS_WIDTH-1:LANE_WIDTH];
  assign wr_lane = wr_addr[LANE_WIDTH-1:0];

  // narrow write port, one beat lane per cycle
  always_ff @(posedge avl_clk) begin
    if (wr_en) begin
      mem[wr_word].lanes[wr_lane] <= wr_data;
    end
  end

  // wide read port, registered
  always_ff @(posedge avl_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== dacfifo_wr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dacfifo_wr_top import dacfifo_pkg::*; (
  input  wire                            avl_clk,
  input  wire                            avl_reset,
  input  wire  [DMA_DATA_WIDTH-1:0]      dma_data,
  input  wire                            dma_valid,
  input  wire                            dma_xfer_req,
  input  wire                            dma_xfer_last,
  output logic                           dma_ready_out,
  output logic                           avl_write,
  output logic [AVL_ADDRESS_WIDTH-1:0]   avl_address,
  output logic [AVL_DATA_WIDTH-1:0]      avl_data,
  output logic [AVL_BE_WIDTH-1:0]        avl_byteenable,
  input  wire                            avl_ready,
  output logic [AVL_ADDRESS_WIDTH-1:0]   avl_last_address,
  output logic [AVL_BE_WIDTH-1:0]        avl_last_byteenable,
  output logic                           avl_xfer_req
);

  logic                             wr_en;
  logic [DMA_MEM_ADDRESS_WIDTH-1:0] wr_addr;
  logic [DMA_DATA_WIDTH-1:0]        wr_data;
  logic                             flush_start;
  logic [AVL_MEM_ADDRESS_WIDTH:0]   word_count;
  logic [LANE_WIDTH-1:0]            last_lane;
  logic                             fetch_enable;
  logic                             final_word;
  logic                             flush_active;
  logic [AVL_MEM_ADDRESS_WIDTH-1:0] rd_addr;
  avl_word_u                        rd_data;

  // ************************************************************
  // dma side
  // ************************************************************

  dacfifo_beat_packer u_beat_packer (
    .avl_clk        (avl_clk),
    .avl_reset      (avl_reset),
    .dma_data       (dma_data),
    .dma_valid      (dma_valid),
    .dma_xfer_req   (dma_xfer_req),
    .dma_xfer_last  (dma_xfer_last),
    .dma_ready_out  (dma_ready_out),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .flush_start    (flush_start),
    .word_count     (word_count),
    .last_lane      (last_lane)
  );

  dacfifo_word_buffer u_word_buffer (
    .avl_clk  (avl_clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  // ************************************************************
  // avalon side
  // ************************************************************

  dacfifo_avl_writer u_avl_writer (
    .avl_clk       (avl_clk),
    .avl_reset     (avl_reset),
    .flush_active  (flush_active),
    .fetch_enable  (fetch_enable),
    .final_word    (final_word),
    .rd_data       (rd_data),
    .avl_ready     (avl_ready),
    .rd_addr       (rd_addr),
    .avl_write     (avl_write),
    .avl_address   (avl_address),
    .avl_data      (avl_data)
  );

  dacfifo_flush_ctrl u_flush_ctrl (
    .avl_clk              (avl_clk),
    .avl_reset            (avl_reset),
    .dma_xfer_req         (dma_xfer_req),
    .flush_start          (flush_start),
    .word_count           (word_count),
    .last_lane            (last_lane),
    .avl_write            (avl_write),
    .avl_ready            (avl_ready),
    .avl_address          (avl_address),
    .fetch_enable         (fetch_enable),
    .final_word           (final_word),
    .flush_active         (flush_active),
    .avl_byteenable       (avl_byteenable),
    .avl_last_address     (avl_last_address),
    .avl_last_byteenable  (avl_last_byteenable),
    .avl_xfer_req         (avl_xfer_req)
  );

endmodule

`default_nettype wire

// ==== tb_dacfifo_wr.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dacfifo_wr import dacfifo_pkg::*; ();

  logic                          avl_clk = 1'b0;
  logic                          avl_reset;
  logic [DMA_DATA_WIDTH-1:0]     dma_data;
  logic                          dma_valid;
  logic                          dma_xfer_req;
  logic                          dma_xfer_last;
  logic                          avl_ready;
  wire                           dma_ready_out;
  wire                           avl_write;
  wire  [AVL_ADDRESS_WIDTH-1:0]  avl_address;
  wire  [AVL_DATA_WIDTH-1:0]     avl_data;
  wire  [AVL_BE_WIDTH-1:0]       avl_byteenable;
  wire  [AVL_ADDRESS_WIDTH-1:0]  avl_last_address;
  wire  [AVL_BE_WIDTH-1:0]       avl_last_byteenable;
  wire                           avl_xfer_req;

  logic [31:0]                   data_lfsr = 32'he4f8360c;
  logic [31:0]                   ready_lfsr = 32'he4f8360c;
  logic                          stall_mode = 1'b0;
  logic [DMA_DATA_WIDTH-1:0]     beat_q [$];
  int                            errors = 0;
  int                            checks = 0;
  int                            write_count = 0;
  int                            writes_base = 0;
  int                            limit_cycles = 0;
  int                            num_recs = 0;
  int                            rec_test [16];
  int                            rec_beats [16];
  int                            rec_mode [16];
  int                            rec_acc [16];
  int                            rec_writes [16];
  int                            rec_addr [16];
  int                            rec_be [16];
  logic                          waiting = 1'b0;
  logic [AVL_ADDRESS_WIDTH-1:0]  held_address;
  logic [AVL_DATA_WIDTH-1:0]     held_data;
  logic [AVL_BE_WIDTH-1:0]       held_be;

  dacfifo_wr_top u_dacfifo_wr_top (
    .avl_clk              (avl_clk),
    .avl_reset            (avl_reset),
    .dma_data             (dma_data),
    .dma_valid            (dma_valid),
    .dma_xfer_req         (dma_xfer_req),
    .dma_xfer_last        (dma_xfer_last),
    .dma_ready_out        (dma_ready_out),
    .avl_write            (avl_write),
    .avl_address          (avl_address),
    .avl_data             (avl_data),
    .avl_byteenable       (avl_byteenable),
    .avl_ready            (avl_ready),
    .avl_last_address     (avl_last_address),
    .avl_last_byteenable  (avl_last_byteenable),
    .avl_xfer_req         (avl_xfer_req)
  );

  always #10 avl_clk = ~avl_clk;

  // ************************************************************
  // helpers
  // ************************************************************

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [DMA_DATA_WIDTH-1:0] random_beat();
    logic [DMA_DATA_WIDTH-1:0] v;
    v = '0;
    for (int i = 0; i < DMA_DATA_WIDTH; i++) begin
      v = {v[DMA_DATA_WIDTH-2:0], data_lfsr[31]};
      data_lfsr = lfsr_next(data_lfsr);
    end
    return v;
  endfunction

  // the k-th write of a flush counts from the base and wraps after the limit
  function automatic logic [AVL_ADDRESS_WIDTH-1:0] window_address(input int k);
    int span;
    span = int'(AVL_DDR_ADDRESS_LIMIT) - int'(AVL_DDR_BASE_ADDRESS) + 1;
    return AVL_DDR_BASE_ADDRESS + AVL_ADDRESS_WIDTH'(k % span);
  endfunction

  task automatic check_value(input string name, input logic [AVL_DATA_WIDTH-1:0] exp,
                             input logic [AVL_DATA_WIDTH-1:0] got);
    checks++;
    assert (got === exp) else begin
      $display("ERR %0t %s exp %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  // one accepted write against the queued beats with lane 0 lowest
  task automatic score_write();
    logic [AVL_DATA_WIDTH-1:0] exp_word;
    logic [AVL_DATA_WIDTH-1:0] mask;
    logic [AVL_BE_WIDTH-1:0]   exp_be;
    int                        n;
    exp_word = '0;
    mask = '0;
    exp_be = '0;
    n = (beat_q.size() < MEM_RATIO) ? beat_q.size() : MEM_RATIO;
    assert (n > 0) else begin
      $display("write accepted at %0t with no beats left to compare", $time);
      errors++;
    end
    for (int k = 0; k < n; k++) begin
      exp_word[k*DMA_DATA_WIDTH +: DMA_DATA_WIDTH] = beat_q.pop_front();
    end
    for (int b = 0; b < n * DMA_BYTES; b++) begin
      exp_be[b] = 1'b1;
      mask[b*8 +: 8] = 8'hff;
    end
    check_value("avl_address", window_address(write_count - writes_base), avl_address);
    check_value("avl_byteenable", exp_be, avl_byteenable);
    check_value("avl_data", exp_word & mask, avl_data & mask);
    write_count++;
  endtask

  // ************************************************************
  // avalon monitor samples away from the rising edge
  // ************************************************************

  always @(negedge avl_clk) begin
    if (!avl_reset) begin
      if (waiting) begin
        check_value("avl_write", 1, avl_write);
        check_value("avl_address", held_address, avl_address);
        check_value("avl_data", held_data, avl_data);
        check_value("avl_byteenable", held_be, avl_byteenable);
      end
      // status flag stays low while a flush still writes
      if (avl_write) begin
        check_value("avl_xfer_req", 0, avl_xfer_req);
      end
      if (avl_write && avl_ready) begin
        score_write();
      end
      waiting = avl_write & ~avl_ready;
      held_address = avl_address;
      held_data = avl_data;
      held_be = avl_byteenable;
    end
  end

  // avalon ready is random only in stall mode
  initial begin
    avl_ready = 1'b1;
    forever begin
      @(posedge avl_clk);
      #2;
      if (stall_mode) begin
        avl_ready = ready_lfsr[31];
        ready_lfsr = lfsr_next(ready_lfsr);
      end else begin
        avl_ready = 1'b1;
      end
    end
  end

  task automatic run_test(input int idx);
    int sent;
    int err_before;
    bit stop;
    err_before = errors;
    writes_base = write_count;
    sent = 0;
    stop = 1'b0;
    @(negedge avl_clk);
    stall_mode = (rec_mode[idx] != 0);
    @(posedge avl_clk);
    #2;
    dma_xfer_req = 1'b1;
    while (!stop) begin
      @(posedge avl_clk);
      #2;
      // the previous ready flag drops once the frame opens
      if (sent == 0 && dma_ready_out) begin
        check_value("avl_xfer_req", 0, avl_xfer_req);
      end
      if (dma_ready_out && sent < rec_beats[idx]) begin
        dma_valid = 1'b1;
        dma_data = random_beat();
        dma_xfer_last = (sent == rec_beats[idx] - 1);
        beat_q.push_back(dma_data);
        sent++;
      end else begin
        dma_valid = 1'b0;
        dma_xfer_last = 1'b0;
        stop = (sent == rec_beats[idx]) || (sent > 0 && !dma_ready_out);
      end
    end
    dma_xfer_req = 1'b0;
    while (!avl_xfer_req) begin
      @(posedge avl_clk);
      #2;
    end
    check_value("accepted beats", rec_acc[idx], sent);
    check_value("write count", rec_writes[idx], write_count - writes_base);
    check_value("avl_last_address", rec_addr[idx], avl_last_address);
    check_value("avl_last_byteenable", rec_be[idx], avl_last_byteenable);
    assert (beat_q.size() == 0) else begin
      $display("test %0d left %0d beats that were never written", rec_test[idx], beat_q.size());
      errors++;
    end
    $display("test %0d: %0d beats, %0d writes, %s", rec_test[idx], sent,
             write_count - writes_base, (errors == err_before) ? "ok" : "failed");
    repeat (3) @(posedge avl_clk);
  endtask

  // ************************************************************
  // main sequence
  // ************************************************************

  initial begin
    int    fd;
    int    total;
    int    t;
    int    b;
    int    m;
    int    a;
    int    w;
    int    la;
    int    be;
    string line;
    total = 0;
    avl_reset = 1'b1;
    dma_data = '0;
    dma_valid = 1'b0;
    dma_xfer_req = 1'b0;
    dma_xfer_last = 1'b0;
    fd = $fopen("dacfifo_trace.txt", "r");
    if (fd == 0) begin
      $display("trace file dacfifo_trace.txt could not be opened");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          if ($sscanf(line, "%d %d %d %d %d %d %h", t, b, m, a, w, la, be) == 7) begin
            rec_test[num_recs] = t;
            rec_beats[num_recs] = b;
            rec_mode[num_recs] = m;
            rec_acc[num_recs] = a;
            rec_writes[num_recs] = w;
            rec_addr[num_recs] = la;
            rec_be[num_recs] = be;
            num_recs++;
            total += b;
          end
        end
      end
      $fclose(fd);
    end
    limit_cycles = total * 40 + 500;
    repeat (8) @(posedge avl_clk);
    #2;
    avl_reset = 1'b0;
    check_value("dma_ready_out", 0, dma_ready_out);
    check_value("avl_write", 0, avl_write);
    check_value("avl_xfer_req", 0, avl_xfer_req);
    check_value("avl_last_address", 0, avl_last_address);
    check_value("avl_last_byteenable", 0, avl_last_byteenable);
    for (int i = 0; i < num_recs; i++) begin
      run_test(i);
    end
    $display("tests %0d, checks %0d, errors %0d", num_recs, checks, errors);
    if (errors == 0 && num_recs > 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge avl_clk);
    $display("timeout after %0d cycles, a frame or flush never completed", limit_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
dacfifo_pkg.sv
dacfifo_word_buffer.sv
dacfifo_beat_packer.sv
dacfifo_avl_writer.sv
dacfifo_flush_ctrl.sv
dacfifo_wr_top.sv
tb_dacfifo_wr.sv
